// ==== hw/mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

    // primary opcodes used by the multiply test program
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDIU   = 6'b001001,
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } op_t;

    // funct field of the special opcode
    typedef enum logic [5:0] {
        FN_JR   = 6'b001000,
        FN_MFHI = 6'b010000,
        FN_MFLO = 6'b010010,
        FN_MULT = 6'b011000
    } funct_t;

    typedef logic [4:0] reg_idx_t;

    // register format
    typedef struct packed {
        op_t      op;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic [4:0] shamt;
        funct_t   funct;
    } r_fields_t;

    // immediate format, also used for loads and stores
    typedef struct packed {
        op_t      op;
        reg_idx_t rs;
        reg_idx_t rt;
        logic [15:0] imm;
    } i_fields_t;

    // jump format
    typedef struct packed {
        op_t         op;
        logic [25:0] target;
    } j_fields_t;

    // one instruction word seen through each encoding
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } instr_t;

endpackage

`default_nettype wire

// ==== hw/mips_bus_pkg.sv ====
`default_nettype none

package mips_bus_pkg;

    // wishbone classic master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== hw/mult_test_iram.sv ====
`timescale 1ns/1ps
`default_nettype none

module mult_test_iram #(
    parameter logic [31:0] RESET_PC   = 32'hBFC00000,
    parameter int          IRAM_WORDS = 4096
) (
    input  logic [31:0] instr_address,
    output logic [31:0] instr_readdata
);

    import mips_isa_pkg::*;

    localparam int AW = $clog2(IRAM_WORDS);

    logic [31:0] rom [IRAM_WORDS];
    logic [31:0] offset;

    // immediate-format word
    function automatic instr_t mk_i(op_t op, reg_idx_t rs, reg_idx_t rt, logic [15:0] imm);
        instr_t w;
        w.i.op  = op;
        w.i.rs  = rs;
        w.i.rt  = rt;
        w.i.imm = imm;
        return w;
    endfunction

    // special-opcode word, shamt always zero here
    function automatic instr_t mk_r(funct_t fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
        instr_t w;
        w.r.op    = OP_SPECIAL;
        w.r.rs    = rs;
        w.r.rt    = rt;
        w.r.rd    = rd;
        w.r.shamt = 5'd0;
        w.r.funct = fn;
        return w;
    endfunction

    initial begin
        int wa;
        wa = 0;
        for (int n = 0; n < IRAM_WORDS; n++) begin
            rom[n] = '0;
        end
        // phase 1: lw r2..r16 from 0x0..0x38
        for (int k = 0; k < 15; k++) begin
            rom[wa] = mk_i(OP_LW, 5'd0, reg_idx_t'(k + 2), 16'(4 * k));
            wa++;
        end
        // phase 2: neighbour products, lo back over r(i-1), hi into r(i+14)
        for (int i = 3; i <= 16; i++) begin
            rom[wa] = mk_r(FN_MULT, reg_idx_t'(i - 1), reg_idx_t'(i), 5'd0);
            wa++;
            rom[wa] = mk_r(FN_MFLO, 5'd0, 5'd0, reg_idx_t'(i - 1));
            wa++;
            rom[wa] = mk_r(FN_MFHI, 5'd0, 5'd0, reg_idx_t'(i + 14));
            wa++;
        end
        // phase 3: hi/lo pairs to 0x400 upwards, hi word first
        for (int i = 17; i <= 30; i++) begin
            rom[wa] = mk_i(OP_SW, 5'd0, reg_idx_t'(i), 16'(16'h400 + (i - 17) * 8));
            wa++;
            rom[wa] = mk_i(OP_SW, 5'd0, reg_idx_t'(i - 15), 16'(16'h404 + (i - 17) * 8));
            wa++;
        end
        // jr r0 ends the run after its delay slot
        rom[wa] = mk_r(FN_JR, 5'd0, 5'd0, 5'd0);
        wa++;
        // delay slot, addiu r2, r0, 0
        rom[wa] = mk_i(OP_ADDIU, 5'd0, 5'd2, 16'h0);
    end

    // fetch address is relative to the boot vector
    assign offset = instr_address % RESET_PC;
    assign instr_readdata = rom[offset[AW+1:2]];

endmodule

`default_nettype wire

// ==== hw/mips_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mips_isa_pkg::reg_idx_t rs_idx,
    input  mips_isa_pkg::reg_idx_t rt_idx,
    output logic [31:0]           rs_data,
    output logic [31:0]           rt_data,
    input  logic                  wr_en,
    input  mips_isa_pkg::reg_idx_t wr_idx,
    input  logic [31:0]           wr_data
);

    logic [31:0] regs [32];

    // r0 is never written, so it keeps its reset value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int n = 0; n < 32; n++) begin
                regs[n] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // combinational reads
    assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
    assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

    a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_en && wr_idx == '0) |=> (regs[0] == '0));

endmodule

`default_nettype wire

// ==== hw/mips_muldiv.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_muldiv (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic [31:0] op_a,
    input  logic [31:0] op_b,
    output logic        busy,
    output logic [31:0] hi,
    output logic [31:0] lo
);

    logic [63:0] mcand;
    logic [63:0] acc;
    logic [63:0] acc_next;
    logic [31:0] mplier;
    logic [31:0] abs_a;
    logic [31:0] abs_b;
    logic [4:0]  step;
    logic        neg;

    // operand magnitudes, 0x80000000 maps onto itself as unsigned 2^31
    assign abs_a = op_a[31] ? -op_a : op_a;
    assign abs_b = op_b[31] ? -op_b : op_b;

    // add shifted multiplicand when the current multiplier bit is set
    assign acc_next = mplier[0] ? acc + mcand : acc;

    // control: busy for exactly 32 steps after start
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            step <= '0;
        end else if (start) begin
            busy <= 1'b1;
            step <= '0;
        end else if (busy) begin
            step <= step + 5'd1;
            if (step == 5'd31) begin
                busy <= 1'b0;
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= {32'b0, abs_a};
            mplier <= abs_b;
            acc    <= '0;
            neg    <= op_a[31] ^ op_b[31];
        end else if (busy) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            // last step: restore the sign and publish the result
            if (step == 5'd31) begin
                {hi, lo} <= neg ? -acc_next : acc_next;
            end
        end
    end

    // the core interlocks mult issue on busy
    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !start);

endmodule

`default_nettype wire

// ==== hw/mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core #(
    parameter logic [31:0] RESET_PC = 32'hBFC00000
) (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic [31:0]            instr_address,
    input  logic [31:0]            instr_readdata,
    output mips_isa_pkg::reg_idx_t rs_idx,
    output mips_isa_pkg::reg_idx_t rt_idx,
    input  logic [31:0]            rs_data,
    input  logic [31:0]            rt_data,
    output logic                   wr_en,
    output mips_isa_pkg::reg_idx_t wr_idx,
    output logic [31:0]            wr_data,
    output logic                   md_start,
    output logic [31:0]            md_a,
    output logic [31:0]            md_b,
    input  logic                   md_busy,
    input  logic [31:0]            md_hi,
    input  logic [31:0]            md_lo,
    output mips_bus_pkg::wb_req_t  wb_req,
    input  mips_bus_pkg::wb_rsp_t  wb_rsp,
    output logic                   halted
);

    import mips_isa_pkg::*;

    typedef enum logic [1:0] {
        S_RUN,
        S_MEM,
        S_HALT
    } state_t;

    state_t      state;
    logic [31:0] pc;
    logic [31:0] npc;
    instr_t      ins;
    logic        is_special;
    logic        is_lw;
    logic        is_sw;
    logic        is_addiu;
    logic        is_mult;
    logic        is_mflo;
    logic        is_mfhi;
    logic        is_jr;
    logic        is_mem;
    logic        stall;
    logic        advance;
    logic [31:0] imm_sext;
    logic [31:0] ea;

    // decode, the word is held stable through the mem state since pc is
    assign ins           = instr_readdata;
    assign instr_address = pc;
    assign rs_idx        = ins.r.rs;
    assign rt_idx        = ins.r.rt;

    assign is_special = ins.r.op == OP_SPECIAL;
    assign is_lw      = ins.i.op == OP_LW;
    assign is_sw      = ins.i.op == OP_SW;
    assign is_addiu   = ins.i.op == OP_ADDIU;
    assign is_mult    = is_special && ins.r.funct == FN_MULT;
    assign is_mflo    = is_special && ins.r.funct == FN_MFLO;
    assign is_mfhi    = is_special && ins.r.funct == FN_MFHI;
    assign is_jr      = is_special && ins.r.funct == FN_JR;
    assign is_mem     = is_lw || is_sw;

    // interlock anything touching the multiplier while it runs
    assign stall = (is_mult || is_mflo || is_mfhi) && md_busy;

    // instruction retires this cycle
    assign advance = (state == S_RUN && !stall && !is_mem) ||
                     (state == S_MEM && wb_rsp.ack);

    assign imm_sext = {{16{ins.i.imm[15]}}, ins.i.imm};
    assign ea       = rs_data + imm_sext;

    assign md_start = state == S_RUN && is_mult && !md_busy;
    assign md_a     = rs_data;
    assign md_b     = rt_data;

    assign halted = state == S_HALT;

    // write-back, lw data goes straight in on the ack cycle
    always_comb begin
        wr_en   = 1'b0;
        wr_idx  = ins.i.rt;
        wr_data = ea;
        if (state == S_RUN && !stall) begin
            if (is_addiu) begin
                wr_en = 1'b1;
            end else if (is_mflo || is_mfhi) begin
                wr_en   = 1'b1;
                wr_idx  = ins.r.rd;
                wr_data = is_mflo ? md_lo : md_hi;
            end
        end else if (state == S_MEM && wb_rsp.ack && is_lw) begin
            wr_en   = 1'b1;
            wr_data = wb_rsp.dat;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= S_RUN;
            pc         <= RESET_PC;
            npc        <= RESET_PC + 32'd4;
            wb_req.cyc <= 1'b0;
            wb_req.stb <= 1'b0;
            wb_req.we  <= 1'b0;
        end else begin
            case (state)
                S_RUN: begin
                    if (is_mem) begin
                        // open the bus cycle, held until ack
                        state      <= S_MEM;
                        wb_req.cyc <= 1'b1;
                        wb_req.stb <= 1'b1;
                        wb_req.we  <= is_sw;
                        wb_req.adr <= ea;
                        wb_req.dat <= rt_data;
                        wb_req.sel <= 4'hf;
                    end
                end
                S_MEM: begin
                    if (wb_rsp.ack) begin
                        wb_req.cyc <= 1'b0;
                        wb_req.stb <= 1'b0;
                        wb_req.we  <= 1'b0;
                    end
                end
                default: begin
                    // halted until reset
                end
            endcase
            // delay slot: the jr target lands in npc, pc walks into the slot
            if (advance) begin
                pc    <= npc;
                npc   <= is_jr ? rs_data : npc + 32'd4;
                // jump to zero means the slot just retired, stop
                state <= (npc == '0) ? S_HALT : S_RUN;
            end
        end
    end

    a_stb_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req.stb |-> wb_req.cyc);

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_req.stb && !wb_rsp.ack) |=>
            ($stable(wb_req.adr) && $stable(wb_req.we) && $stable(wb_req.dat)));

endmodule

`default_nettype wire

// ==== hw/mips_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_top #(
    parameter logic [31:0] RESET_PC   = 32'hBFC00000,
    parameter int          IRAM_WORDS = 4096
) (
    input  logic                  clk,
    input  logic                  rst_n,
    output mips_bus_pkg::wb_req_t wb_req,
    input  mips_bus_pkg::wb_rsp_t wb_rsp,
    output logic                  halted
);

    import mips_isa_pkg::*;

    // fetch
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    // register file
    reg_idx_t    rs_idx;
    reg_idx_t    rt_idx;
    reg_idx_t    wr_idx;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] wr_data;
    logic        wr_en;
    // multiplier
    logic        md_start;
    logic        md_busy;
    logic [31:0] md_a;
    logic [31:0] md_b;
    logic [31:0] md_hi;
    logic [31:0] md_lo;

    mips_core #(
        .RESET_PC(RESET_PC)
    ) core0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_address (instr_address),
        .instr_readdata(instr_readdata),
        .rs_idx        (rs_idx),
        .rt_idx        (rt_idx),
        .rs_data       (rs_data),
        .rt_data       (rt_data),
        .wr_en         (wr_en),
        .wr_idx        (wr_idx),
        .wr_data       (wr_data),
        .md_start      (md_start),
        .md_a          (md_a),
        .md_b          (md_b),
        .md_busy       (md_busy),
        .md_hi         (md_hi),
        .md_lo         (md_lo),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp),
        .halted        (halted)
    );

    mult_test_iram #(
        .RESET_PC  (RESET_PC),
        .IRAM_WORDS(IRAM_WORDS)
    ) iram0 (
        .instr_address (instr_address),
        .instr_readdata(instr_readdata)
    );

    mips_regfile rf0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs_idx (rs_idx),
        .rt_idx (rt_idx),
        .rs_data(rs_data),
        .rt_data(rt_data),
        .wr_en  (wr_en),
        .wr_idx (wr_idx),
        .wr_data(wr_data)
    );

    mips_muldiv md0 (
        .clk  (clk),
        .rst_n(rst_n),
        .start(md_start),
        .op_a (md_a),
        .op_b (md_b),
        .busy (md_busy),
        .hi   (md_hi),
        .lo   (md_lo)
    );

endmodule

`default_nettype wire

// ==== tests/tb_mips_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mips_top;

    import mips_bus_pkg::*;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 5;
    localparam logic [31:0] LFSR_SEED    = 32'h3f81_893f;
    localparam logic [31:0] STORE_BASE   = 32'h400;
    // shape of the program in loads, mult/mflo/mfhi triples, stores, jr and its slot
    localparam int N_LOADS  = 15;
    localparam int N_PROD   = 14;
    localparam int N_STORES = 2 * N_PROD;
    localparam int N_XFERS  = N_LOADS + N_STORES;
    localparam int N_INSTR  = N_LOADS + 3 * N_PROD + N_STORES + 2;
    // worst memory op takes issue, up to 3 wait states, ack and retire
    localparam int MAX_WAIT    = 3;
    localparam int WORST_STALL = MAX_WAIT + 3;
    localparam int MULT_LAT    = 34;
    localparam int RUN_CYCLES  = N_INSTR * WORST_STALL + N_PROD * MULT_LAT + 200;
    localparam int HALT_WATCH  = 50;
    localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + RUN_CYCLES + HALT_WATCH) + 100;

    logic    clk;
    logic    rst_n;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp = '0;
    logic    halted;

    // stimulus and bookkeeping of the main process
    logic [31:0] lfsr = LFSR_SEED;
    logic [31:0] init_mem [logic [31:0]];
    int          wait_plan [64];
    int          tests_run;
    int          tests_failed;
    int          errors;
    int          reset_errs;
    logic        halt_rose;

    // slave model and bus monitor state
    logic [31:0] wr_mem [logic [31:0]];
    logic [31:0] log_adr [$];
    logic        log_we [$];
    logic [31:0] log_dat [$];
    logic        open_xfer;
    int          wait_left;
    logic [31:0] cap_adr;
    logic [31:0] cap_dat;
    logic        cap_we;
    int          starts;
    int          acks;
    int          bp_errs;
    logic        halt_seen;
    int          acks_at_halt;
    int          post_halt_bus;
    int          halt_drops;

    mips_top #(
        .RESET_PC  (32'hBFC00000),
        .IRAM_WORDS(4096)
    ) dut0 (
        .clk   (clk),
        .rst_n (rst_n),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // fibonacci lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // n bits msb first with one lfsr step for each
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v    = {v[30:0], lfsr[31]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // signed 32x32 product with both factors sign-extended to 64 bits
    function automatic logic [63:0] ref_product(input logic [31:0] a, input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        return sa * sb;
    endfunction

    // stored words take precedence over the preload
    function automatic logic [31:0] read_word(input logic [31:0] a);
        if (wr_mem.exists(a)) begin
            return wr_mem[a];
        end
        if (init_mem.exists(a)) begin
            return init_mem[a];
        end
        // untouched words follow their address
        return a ^ 32'h5a5a_a5a5;
    endfunction

    // wishbone classic slave driving on the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            wb_rsp        = '0;
            open_xfer     = 1'b0;
            wait_left     = 0;
            starts        = 0;
            acks          = 0;
            bp_errs       = 0;
            halt_seen     = 1'b0;
            acks_at_halt  = 0;
            post_halt_bus = 0;
            halt_drops    = 0;
            wr_mem.delete();
            log_adr.delete();
            log_we.delete();
            log_dat.delete();
        end else begin
            if (wb_rsp.ack) begin
                // master took the ack at the last rising edge and dropped stb
                wb_rsp.ack = 1'b0;
                open_xfer  = 1'b0;
            end else if (wb_req.cyc && wb_req.stb) begin
                if (!open_xfer) begin
                    // capture a new request and draw its wait states
                    open_xfer = 1'b1;
                    cap_adr   = wb_req.adr;
                    cap_we    = wb_req.we;
                    cap_dat   = wb_req.dat;
                    wait_left = (starts < 64) ? wait_plan[starts] : 0;
                    starts++;
                    // word accesses only
                    if (wb_req.sel !== 4'hf) begin
                        $display("FAIL wb_req.sel: expected 0xf got 0x%0h", wb_req.sel);
                        bp_errs++;
                    end
                end else begin
                    if (wb_req.adr !== cap_adr) begin
                        $display("FAIL wb_req.adr moved during wait: expected 0x%08h got 0x%08h",
                                 cap_adr, wb_req.adr);
                        bp_errs++;
                    end
                    if (wb_req.we !== cap_we) begin
                        $display("FAIL wb_req.we moved during wait: expected 0x%0h got 0x%0h",
                                 cap_we, wb_req.we);
                        bp_errs++;
                    end
                    if (wb_req.dat !== cap_dat) begin
                        $display("FAIL wb_req.dat moved during wait: expected 0x%08h got 0x%08h",
                                 cap_dat, wb_req.dat);
                        bp_errs++;
                    end
                end
                if (wait_left == 0) begin
                    wb_rsp.ack = 1'b1;
                    acks++;
                    log_adr.push_back(wb_req.adr);
                    log_we.push_back(wb_req.we);
                    if (wb_req.we) begin
                        wr_mem[wb_req.adr] = wb_req.dat;
                        log_dat.push_back(wb_req.dat);
                    end else begin
                        wb_rsp.dat = read_word(wb_req.adr);
                        log_dat.push_back(wb_rsp.dat);
                    end
                end else begin
                    wait_left--;
                end
            end
            // no request may start once halted
            if (halted) begin
                if (!halt_seen) begin
                    halt_seen    = 1'b1;
                    acks_at_halt = acks;
                end
                if (wb_req.cyc || wb_req.stb) begin
                    post_halt_bus++;
                end
            end else if (halt_seen) begin
                halt_drops++;
            end
        end
    end

    task automatic report_test(input string name, input int run, input int errs);
        tests_run++;
        errors += errs;
        if (errs == 0) begin
            $display("test %s, run %0d: ok", name, run);
        end else begin
            tests_failed++;
            $display("test %s, run %0d: %0d errors", name, run, errs);
        end
    endtask

    // first fifteen transfers read 0x0..0x38 in order
    task automatic check_load_order(input int run);
        int errs;
        errs = 0;
        if (log_adr.size() < N_LOADS) begin
            $display("run %0d saw only %0d bus transfers before the loads ended", run,
                     log_adr.size());
            errs++;
        end else begin
            for (int k = 0; k < N_LOADS; k++) begin
                if (log_we[k] !== 1'b0) begin
                    $display("FAIL wb_req.we load %0d: expected 0x0 got 0x%0h", k, log_we[k]);
                    errs++;
                end
                if (log_adr[k] !== 32'(4 * k)) begin
                    $display("FAIL wb_req.adr load %0d: expected 0x%08h got 0x%08h", k,
                             32'(4 * k), log_adr[k]);
                    errs++;
                end
            end
        end
        report_test("load order", run, errs);
    endtask

    // hi word then lo word of each neighbour product
    task automatic check_products(input int run);
        logic [63:0] prod;
        logic [31:0] exp_adr;
        logic [31:0] exp_dat;
        int          idx;
        int          errs;
        errs = 0;
        if (log_adr.size() != N_XFERS) begin
            $display("run %0d saw %0d bus transfers instead of %0d", run, log_adr.size(),
                     N_XFERS);
            errs++;
        end
        for (int k = 0; k < N_PROD; k++) begin
            prod = ref_product(init_mem[32'(4 * k)], init_mem[32'(4 * (k + 1))]);
            for (int h = 0; h < 2; h++) begin
                idx     = N_LOADS + 2 * k + h;
                exp_adr = STORE_BASE + 32'(8 * k + 4 * h);
                exp_dat = (h == 0) ? prod[63:32] : prod[31:0];
                if (idx >= log_adr.size()) begin
                    $display("store %0d of run %0d never reached the bus", idx - N_LOADS, run);
                    errs++;
                end else begin
                    if (log_we[idx] !== 1'b1) begin
                        $display("FAIL wb_req.we store %0d: expected 0x1 got 0x%0h",
                                 idx - N_LOADS, log_we[idx]);
                        errs++;
                    end
                    if (log_adr[idx] !== exp_adr) begin
                        $display("FAIL wb_req.adr store %0d: expected 0x%08h got 0x%08h",
                                 idx - N_LOADS, exp_adr, log_adr[idx]);
                        errs++;
                    end
                    if (log_dat[idx] !== exp_dat) begin
                        $display("FAIL wb_req.dat store %0d: expected 0x%08h got 0x%08h",
                                 idx - N_LOADS, exp_dat, log_dat[idx]);
                        errs++;
                    end
                end
            end
        end
        report_test("products", run, errs);
    endtask

    // transfer counts plus the hold and sel violations seen by the slave
    task automatic check_back_pressure(input int run);
        int errs;
        errs = bp_errs;
        if (starts != acks) begin
            $display("run %0d started %0d transfers but acknowledged %0d", run, starts, acks);
            errs++;
        end
        if (acks != N_XFERS) begin
            $display("run %0d completed %0d transfers instead of %0d", run, acks, N_XFERS);
            errs++;
        end
        report_test("back-pressure", run, errs);
    endtask

    task automatic check_halt(input int run);
        int errs;
        errs = reset_errs;
        if (!halt_rose) begin
            $display("halted never rose within %0d cycles in run %0d", RUN_CYCLES, run);
            errs++;
        end else if (acks_at_halt != N_XFERS) begin
            $display("halted rose after %0d of %0d transfers in run %0d", acks_at_halt,
                     N_XFERS, run);
            errs++;
        end
        if (post_halt_bus != 0) begin
            $display("bus request seen in %0d cycles after halt in run %0d", post_halt_bus, run);
            errs++;
        end
        if (halt_drops != 0) begin
            $display("halted fell again during run %0d", run);
            errs++;
        end
        report_test("halt", run, errs);
    endtask

    // reset, preload memory and wait states, run to halt, check
    task automatic run_program(input int run, input logic force_neg);
        logic [31:0] w;
        int          cycles;
        rst_n      = 1'b0;
        reset_errs = 0;
        init_mem.delete();
        for (int j = 0; j < N_LOADS; j++) begin
            w = take_bits(32);
            // every third word negative on the rerun
            if (force_neg && j % 3 == 1) begin
                w[31] = 1'b1;
            end
            init_mem[32'(4 * j)] = w;
        end
        for (int n = 0; n < 64; n++) begin
            wait_plan[n] = int'(take_bits(2));
        end
        repeat (RESET_CYCLES) @(negedge clk);
        if (wb_req.cyc !== 1'b0 || wb_req.stb !== 1'b0 || wb_req.we !== 1'b0 ||
            halted !== 1'b0) begin
            $display("reset left the bus request or halted active in run %0d", run);
            reset_errs++;
        end
        rst_n  = 1'b1;
        cycles = 0;
        while (halted !== 1'b1 && cycles < RUN_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        halt_rose = halted;
        // keep watching the bus while halted
        repeat (HALT_WATCH) @(negedge clk);
        check_load_order(run);
        check_products(run);
        check_back_pressure(run);
        check_halt(run);
    endtask

    initial begin
        rst_n        = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        errors       = 0;
        halt_rose    = 1'b0;
        run_program(1, 1'b0);
        // second pass with signed operands guaranteed
        run_program(2, 1'b1);
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // two runs at their worst-case length plus slack
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles without the run ending", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/mips_isa_pkg.sv
hw/mips_bus_pkg.sv
hw/mult_test_iram.sv
hw/mips_regfile.sv
hw/mips_muldiv.sv
hw/mips_core.sv
hw/mips_top.sv
tests/tb_mips_top.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_mips_top -f verilog.f
out=$(./obj_dir/Vtb_mips_top)
echo "$out"
# success only when the pass line is present
echo "$out" | grep -qx "Result: PASSED"
